// ==== source/alu_pkg.sv ====
// Shared ALU and controller types; opcode constants cover only OP, OP-IMM and LUI.
`default_nettype none

package alu_pkg;

    // ALU operations. PASS forwards operand b.
    typedef enum logic [3:0] {
        ADD  = 4'd0,
        SUB  = 4'd1,
        XOR  = 4'd2,
        OR   = 4'd3,
        AND  = 4'd4,
        SLL  = 4'd5,
        SRL  = 4'd6,
        SRA  = 4'd7,
        SLT  = 4'd8,
        SLTU = 4'd9,
        PASS = 4'd10
    } alu_op_e;

    // Four-phase controller states.
    typedef enum logic [1:0] {
        IDLE    = 2'd0, // Waiting for req.
        EXECUTE = 2'd1, // Captured, result being formed.
        RESPOND = 2'd2, // Ack raised, waiting for req to drop.
        RELEASE = 2'd3  // Ack being lowered.
    } exec_state_e;

    // RV32I major opcodes, instr[6:0].
    localparam logic [6:0] OPC_OP     = 7'b0110011;
    localparam logic [6:0] OPC_OP_IMM = 7'b0010011;
    localparam logic [6:0] OPC_LUI    = 7'b0110111;

endpackage

`default_nettype wire

// ==== source/alu_if.sv ====
// Carries op, operands and result between requester and ALU; no clock, purely combinational.
`default_nettype none

interface alu_if #(
    parameter int XLEN = 32
);
    import alu_pkg::*;

    alu_op_e         op;
    logic [XLEN-1:0] operand_a;
    logic [XLEN-1:0] operand_b;
    logic [XLEN-1:0] result;

    // Side that decodes and supplies operands.
    modport requester (
        output op,
        output operand_a,
        output operand_b,
        input  result
    );

    modport alu (
        input  op,
        input  operand_a,
        input  operand_b,
        output result
    );

endinterface

`default_nettype wire

// ==== source/sklansky_adder.sv ====
// Combinational prefix adder without carry-in or carry-out; the sum wraps at WIDTH bits.
`default_nettype none

module sklansky_adder #(
    parameter int WIDTH = 33
) (
    input  wire logic [WIDTH-1:0] a_i,
    input  wire logic [WIDTH-1:0] b_i,
    output logic      [WIDTH-1:0] sum_o
);

    localparam int LEVELS = $clog2(WIDTH);

    // Group generate per level, level 0 is per bit.
    wire [WIDTH-1:0] g_lvl [0:LEVELS];
    // Group propagate, the last level is never needed.
    wire [WIDTH-1:0] p_lvl [0:LEVELS-1];

    assign g_lvl[0] = a_i & b_i;
    assign p_lvl[0] = a_i ^ b_i;

    genvar lvl;
    genvar bit_idx;
    generate
        for (lvl = 0; lvl < LEVELS; lvl++) begin : g_level
            for (bit_idx = 0; bit_idx < WIDTH; bit_idx++) begin : g_bit
                // Last bit of the lower half of this block.
                localparam int SRC = ((bit_idx >> lvl) << lvl) - 1;

                if (((bit_idx >> lvl) & 1) == 1) begin : g_merge
                    assign g_lvl[lvl+1][bit_idx] = g_lvl[lvl][bit_idx] |
                        (p_lvl[lvl][bit_idx] & g_lvl[lvl][SRC]);
                    if (lvl + 1 < LEVELS) begin : g_prop
                        assign p_lvl[lvl+1][bit_idx] = p_lvl[lvl][bit_idx] & p_lvl[lvl][SRC];
                    end
                end else begin : g_pass
                    assign g_lvl[lvl+1][bit_idx] = g_lvl[lvl][bit_idx];
                    if (lvl + 1 < LEVELS) begin : g_prop
                        assign p_lvl[lvl+1][bit_idx] = p_lvl[lvl][bit_idx];
                    end
                end
            end
        end
    endgenerate

    // Carry into bit i is the group generate of bits i-1 down to 0.
    assign sum_o[0] = p_lvl[0][0];

    generate
        for (bit_idx = 1; bit_idx < WIDTH; bit_idx++) begin : g_sum
            assign sum_o[bit_idx] = p_lvl[0][bit_idx] ^ g_lvl[LEVELS][bit_idx-1];
        end
    endgenerate

endmodule

`default_nettype wire

// ==== source/alu.sv ====
// Combinational ALU; shifts use only the low log2(XLEN) bits of operand b.
`default_nettype none

module alu #(
    parameter int XLEN = 32
) (
    alu_if.alu bus
);
    import alu_pkg::*;

    localparam int SHW = $clog2(XLEN);

    logic            is_sub;
    logic [XLEN:0]   add_a;
    logic [XLEN:0]   add_b;
    logic [XLEN:0]   add_sum;
    logic [SHW-1:0]  shamt;
    logic [XLEN-1:0] res_xor;
    logic [XLEN-1:0] res_or;
    logic [XLEN-1:0] res_and;
    logic [XLEN-1:0] res_sll;
    logic [XLEN-1:0] res_srl;
    logic [XLEN-1:0] res_sra;
    logic            lt_signed;
    logic            lt_unsigned;

    assign is_sub = (bus.op == SUB);

    // Extra low bit acts as carry-in: a - b = a + ~b + 1.
    assign add_a = {bus.operand_a, is_sub};
    assign add_b = is_sub ? {~bus.operand_b, 1'b1} : {bus.operand_b, 1'b0};

    sklansky_adder #(
        .WIDTH(XLEN + 1)
    ) u_adder (
        .a_i  (add_a),
        .b_i  (add_b),
        .sum_o(add_sum)
    );

    assign shamt = bus.operand_b[SHW-1:0];

    assign res_xor = bus.operand_a ^ bus.operand_b;
    assign res_or  = bus.operand_a | bus.operand_b;
    assign res_and = bus.operand_a & bus.operand_b;
    assign res_sll = bus.operand_a << shamt;
    assign res_srl = bus.operand_a >> shamt;
    assign res_sra = $signed(bus.operand_a) >>> shamt; // Sign fill.

    assign lt_signed   = $signed(bus.operand_a) < $signed(bus.operand_b);
    assign lt_unsigned = bus.operand_a < bus.operand_b;

    always_comb begin
        case (bus.op)
            ADD, SUB: bus.result = add_sum[XLEN:1];
            XOR:      bus.result = res_xor;
            OR:       bus.result = res_or;
            AND:      bus.result = res_and;
            SLL:      bus.result = res_sll;
            SRL:      bus.result = res_srl;
            SRA:      bus.result = res_sra;
            SLT:      bus.result = {{(XLEN-1){1'b0}}, lt_signed};
            SLTU:     bus.result = {{(XLEN-1){1'b0}}, lt_unsigned};
            PASS:     bus.result = bus.operand_b;
            default:  bus.result = '0;
        endcase
    end

endmodule

`default_nettype wire

// ==== source/alu_decoder.sv ====
// Decodes OP, OP-IMM and LUI only; every other opcode is reported illegal.
`default_nettype none

module alu_decoder #(
    parameter int XLEN = 32
) (
    input  wire logic [31:0]     instr_i,
    output alu_pkg::alu_op_e     op_o,
    output logic                 use_imm_o,
    output logic                 zero_a_o,
    output logic [XLEN-1:0]      imm_o,
    output logic                 illegal_o
);
    import alu_pkg::*;

    localparam int SHW = $clog2(XLEN);

    logic [6:0]      opcode;
    logic [2:0]      funct3;
    logic [6:0]      funct7;
    logic            funct7_alt;
    logic [XLEN-1:0] imm_i;
    logic [XLEN-1:0] imm_u;
    logic            slli_bad;
    logic            sri_bad;

    assign opcode = instr_i[6:0];
    assign funct3 = instr_i[14:12];
    assign funct7 = instr_i[31:25];

    assign funct7_alt = (funct7 == 7'b0100000); // SUB and SRA.

    assign imm_i = XLEN'($signed(instr_i[31:20]));
    assign imm_u = XLEN'($signed({instr_i[31:12], 12'h000}));

    // Bits above the shift amount. Bit 30 selects SRAI.
    assign slli_bad = |instr_i[31:20+SHW];
    assign sri_bad  = instr_i[31] | (|instr_i[29:20+SHW]);

    always_comb begin
        op_o      = ADD;
        use_imm_o = 1'b0;
        zero_a_o  = 1'b0;
        imm_o     = imm_i;
        illegal_o = 1'b0;

        case (opcode)
            OPC_OP: begin
                case (funct3)
                    3'b000:  op_o = funct7_alt ? SUB : ADD;
                    3'b001:  op_o = SLL;
                    3'b010:  op_o = SLT;
                    3'b011:  op_o = SLTU;
                    3'b100:  op_o = XOR;
                    3'b101:  op_o = funct7_alt ? SRA : SRL;
                    3'b110:  op_o = OR;
                    default: op_o = AND;
                endcase
                // Alternate funct7 only on ADD/SUB and SRL/SRA.
                if (funct7 != 7'b0000000) begin
                    illegal_o = !(funct7_alt && (funct3 == 3'b000 || funct3 == 3'b101));
                end
            end
            OPC_OP_IMM: begin
                use_imm_o = 1'b1;
                case (funct3)
                    3'b000:  op_o = ADD;
                    3'b001:  op_o = SLL;
                    3'b010:  op_o = SLT;
                    3'b011:  op_o = SLTU;
                    3'b100:  op_o = XOR;
                    3'b101:  op_o = instr_i[30] ? SRA : SRL;
                    3'b110:  op_o = OR;
                    default: op_o = AND;
                endcase
                if (funct3 == 3'b001) begin
                    illegal_o = slli_bad;
                end else if (funct3 == 3'b101) begin
                    illegal_o = sri_bad;
                end
            end
            OPC_LUI: begin
                op_o      = PASS;
                use_imm_o = 1'b1;
                zero_a_o  = 1'b1;
                imm_o     = imm_u;
            end
            default: illegal_o = 1'b1;
        endcase
    end

endmodule

`default_nettype wire

// ==== source/exec_unit.sv ====
// One instruction in flight; req_i and operands must stay stable until ack_o rises.
`default_nettype none

module exec_unit #(
    parameter int XLEN = 32
) (
    input  wire logic            clk_i,
    input  wire logic            arst_n_i,
    input  wire logic            req_i,
    input  wire logic [31:0]     instr_i,
    input  wire logic [XLEN-1:0] rs1_data_i,
    input  wire logic [XLEN-1:0] rs2_data_i,
    output logic                 ack_o,
    output logic [XLEN-1:0]      result_o,
    output logic                 illegal_o
);
    import alu_pkg::*;

    exec_state_e     state_q;
    logic            ack_q;
    logic [XLEN-1:0] result_q;
    logic            illegal_q;

    // Captured request.
    logic [31:0]     instr_q;
    logic [XLEN-1:0] rs1_q;
    logic [XLEN-1:0] rs2_q;

    alu_op_e         dec_op;
    logic            dec_use_imm;
    logic            dec_zero_a;
    logic [XLEN-1:0] dec_imm;
    logic            dec_illegal;

    alu_if #(
        .XLEN(XLEN)
    ) alu_bus ();

    alu_decoder #(
        .XLEN(XLEN)
    ) u_alu_decoder (
        .instr_i  (instr_q),
        .op_o     (dec_op),
        .use_imm_o(dec_use_imm),
        .zero_a_o (dec_zero_a),
        .imm_o    (dec_imm),
        .illegal_o(dec_illegal)
    );

    assign alu_bus.op        = dec_op;
    assign alu_bus.operand_a = dec_zero_a ? '0 : rs1_q;   // LUI ignores rs1.
    assign alu_bus.operand_b = dec_use_imm ? dec_imm : rs2_q;

    alu #(
        .XLEN(XLEN)
    ) u_alu (
        .bus(alu_bus.alu)
    );

    always_ff @(posedge clk_i) begin
        if (state_q == IDLE && req_i) begin
            instr_q <= instr_i;
            rs1_q   <= rs1_data_i;
            rs2_q   <= rs2_data_i;
        end
    end

    // Four-phase controller.
    always_ff @(posedge clk_i or negedge arst_n_i) begin
        if (!arst_n_i) begin
            state_q   <= IDLE;
            ack_q     <= 1'b0;
            result_q  <= '0;
            illegal_q <= 1'b0;
        end else begin
            case (state_q)
                IDLE: begin
                    if (req_i) begin
                        state_q <= EXECUTE;
                    end
                end
                EXECUTE: begin
                    result_q  <= dec_illegal ? '0 : alu_bus.result;
                    illegal_q <= dec_illegal;
                    state_q   <= RESPOND;
                end
                RESPOND: begin
                    ack_q <= 1'b1;
                    // Release only once the requester has seen ack.
                    if (ack_q && !req_i) begin
                        state_q <= RELEASE;
                    end
                end
                default: begin
                    ack_q   <= 1'b0;
                    state_q <= IDLE;
                end
            endcase
        end
    end

    assign ack_o     = ack_q;
    assign result_o  = result_q;
    assign illegal_o = illegal_q;

endmodule

`default_nettype wire

// ==== tests/exec_unit_tb.sv ====
// Runs the DUT at XLEN 32 only; needs a simulator with concurrent assertion support.
`default_nettype none

module exec_unit_tb;
    import alu_pkg::*;

    localparam int HALF_PERIOD      = 50;
    localparam int PERIOD           = 2 * HALF_PERIOD;
    localparam int DRIVE_DELAY      = 10;
    localparam int RESET_CYCLES     = 5;
    localparam int RAND_PER_OP      = 5;
    localparam int NUM_RAND_WORDS   = 15;
    localparam int NUM_DIRECTED     = 33;
    // 10 R-type, 9 I-type and LUI get RAND_PER_OP each.
    localparam int NUM_TRANSACTIONS = NUM_DIRECTED + 20 * RAND_PER_OP + NUM_RAND_WORDS;
    localparam int TIMEOUT          = (NUM_TRANSACTIONS * 10 + RESET_CYCLES + 10) * PERIOD;

    logic        clk = 1'b0;
    logic        arst_n;
    logic        req;
    logic [31:0] instr;
    logic [31:0] rs1_data;
    logic [31:0] rs2_data;
    logic        ack;
    logic [31:0] result;
    logic        illegal;

    logic [31:0] exp_result;
    logic        exp_illegal;
    logic [31:0] lcg_state = 32'd46037;

    exec_unit #(
        .XLEN(32)
    ) u_exec_unit (
        .clk_i     (clk),
        .arst_n_i  (arst_n),
        .req_i     (req),
        .instr_i   (instr),
        .rs1_data_i(rs1_data),
        .rs2_data_i(rs2_data),
        .ack_o     (ack),
        .result_o  (result),
        .illegal_o (illegal)
    );

    always #(HALF_PERIOD) clk = ~clk;

    task automatic abort_run(input string why);
        $display("%s", why);
        $display("Some tests failed");
        $fatal(1);
    endtask

    task automatic report_mismatch(input string name, input logic [31:0] expected,
                                   input logic [31:0] actual);
        abort_run($sformatf("FAILED at time %0t: %s expected 0x%08h, got 0x%08h",
                            $time, name, expected, actual));
    endtask

    // Upper halves of two LCG steps.
    function automatic logic [31:0] rand_word();
        logic [31:0] hi;
        lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
        hi        = lcg_state;
        lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
        return {hi[31:16], lcg_state[31:16]};
    endfunction

    function automatic logic [31:0] enc_r(input logic [6:0] f7, input logic [2:0] f3);
        logic [31:0] regs;
        regs = rand_word(); // Register fields do not matter.
        return {f7, regs[24:15], f3, regs[11:7], OPC_OP};
    endfunction

    function automatic logic [31:0] enc_i(input logic [11:0] imm, input logic [2:0] f3);
        logic [31:0] regs;
        regs = rand_word();
        return {imm, regs[19:15], f3, regs[11:7], OPC_OP_IMM};
    endfunction

    function automatic logic [31:0] enc_u(input logic [19:0] imm);
        logic [31:0] regs;
        regs = rand_word();
        return {imm, regs[11:7], OPC_LUI};
    endfunction

    function automatic logic [31:0] enc_opcode(input logic [6:0] opc);
        logic [31:0] bits;
        bits = rand_word();
        return {bits[31:7], opc};
    endfunction

    // RV32I legality for OP, OP-IMM and LUI.
    function automatic logic model_illegal(input logic [31:0] w);
        logic [6:0] f7;
        logic [2:0] f3;
        f7 = w[31:25];
        f3 = w[14:12];
        case (w[6:0])
            OPC_OP: begin
                return !(f7 == 7'h00 || (f7 == 7'h20 && (f3 == 3'b000 || f3 == 3'b101)));
            end
            OPC_OP_IMM: begin
                if (f3 == 3'b001) begin
                    return f7 != 7'h00;
                end else if (f3 == 3'b101) begin
                    return !(f7 == 7'h00 || f7 == 7'h20);
                end
                return 1'b0;
            end
            OPC_LUI: return 1'b0;
            default: return 1'b1;
        endcase
    endfunction

    function automatic logic [31:0] model_result(input logic [31:0] w, input logic [31:0] a,
                                                 input logic [31:0] b);
        logic [31:0] opb;
        logic [31:0] y;
        logic [4:0]  sh;
        if (model_illegal(w)) begin
            return 32'h0;
        end
        if (w[6:0] == OPC_LUI) begin
            return {w[31:12], 12'h000};
        end
        opb = (w[6:0] == OPC_OP_IMM) ? {{20{w[31]}}, w[31:20]} : b;
        sh  = opb[4:0];
        case (w[14:12])
            3'b000:  y = (w[6:0] == OPC_OP && w[30]) ? a - opb : a + opb;
            3'b001:  y = a << sh;
            3'b010:  y = {31'h0, $signed(a) < $signed(opb)};
            3'b011:  y = {31'h0, a < opb};
            3'b100:  y = a ^ opb;
            3'b101: begin
                if (w[30]) begin
                    y = $signed(a) >>> sh;
                end else begin
                    y = a >> sh;
                end
            end
            3'b110:  y = a | opb;
            default: y = a & opb;
        endcase
        return y;
    endfunction

    // One four-phase transaction; starts and ends just after an edge with ack low.
    task automatic run_transaction(input logic [31:0] word, input logic [31:0] a,
                                   input logic [31:0] b);
        int hold;
        int gap;
        hold        = int'(rand_word() % 4);
        gap         = int'(rand_word() % 2);
        exp_result  = model_result(word, a, b);
        exp_illegal = model_illegal(word);
        instr       = word;
        rs1_data    = a;
        rs2_data    = b;
        req         = 1'b1;
        do begin
            @(posedge clk);
            #DRIVE_DELAY;
        end while (!ack);
        rs1_data = rand_word(); // Result must hold while inputs move.
        rs2_data = rand_word();
        repeat (hold) begin
            @(posedge clk);
            #DRIVE_DELAY;
        end
        req = 1'b0;
        do begin
            @(posedge clk);
            #DRIVE_DELAY;
        end while (ack);
        repeat (gap) begin
            @(posedge clk);
            #DRIVE_DELAY;
        end
    endtask

    // Capture at the first sample of req and ack seen high three samples later.
    ack_rise_timing: assert property (@(posedge clk) disable iff (!arst_n)
        $rose(ack) == ($past(req, 3) && !$past(req, 4)))
        else abort_run("ack_o did not rise exactly two cycles after req_i was captured");

    ack_needs_req: assert property (@(posedge clk) disable iff (!arst_n)
        $rose(ack) |-> $past(req))
        else abort_run("ack_o rose while req_i was low");

    response_hold: assert property (@(posedge clk) disable iff (!arst_n)
        $past(ack) && $past(req) |-> ack && $stable(result) && $stable(illegal))
        else abort_run("ack_o, result_o or illegal_o changed while req_i was held high");

    ack_fall_timing: assert property (@(posedge clk) disable iff (!arst_n)
        $fell(ack) == ($past(ack, 2) && !$past(req, 2) && $past(req, 3)))
        else abort_run("ack_o did not fall one cycle after req_i was sampled low");

    result_value: assert property (@(posedge clk) disable iff (!arst_n)
        ack |-> result == exp_result)
        else report_mismatch("result_o", exp_result, result);

    illegal_value: assert property (@(posedge clk) disable iff (!arst_n)
        ack |-> illegal == exp_illegal)
        else report_mismatch("illegal_o", {31'h0, exp_illegal}, {31'h0, illegal});

    initial begin : stimulus
        int          op_idx;
        int          n;
        logic [31:0] w;
        logic [2:0]  f3;
        logic [6:0]  f7;
        arst_n      = 1'b0;
        req         = 1'b0;
        instr       = 32'h0;
        rs1_data    = 32'h0;
        rs2_data    = 32'h0;
        exp_result  = 32'h0;
        exp_illegal = 1'b0;
        repeat (RESET_CYCLES) @(posedge clk);
        #DRIVE_DELAY;
        reset_clear: assert (!ack && result == 32'h0 && !illegal)
            else abort_run("ack_o, result_o or illegal_o not cleared by reset");
        arst_n = 1'b1;
        @(posedge clk);
        #DRIVE_DELAY;

        // Register-register corners.
        run_transaction(enc_r(7'h00, 3'b000), 32'h7fffffff, 32'h00000001);
        run_transaction(enc_r(7'h20, 3'b000), 32'h80000000, 32'h00000001);
        run_transaction(enc_r(7'h20, 3'b000), 32'h00000000, 32'h00000001);
        run_transaction(enc_r(7'h00, 3'b010), 32'hffffffff, 32'h00000001);
        run_transaction(enc_r(7'h00, 3'b011), 32'hffffffff, 32'h00000001);
        run_transaction(enc_r(7'h00, 3'b010), 32'h00000001, 32'hffffffff);
        run_transaction(enc_r(7'h00, 3'b011), 32'h00000001, 32'hffffffff);
        run_transaction(enc_r(7'h00, 3'b001), 32'h80000001, 32'hffffffe0); // Shift by 0.
        run_transaction(enc_r(7'h00, 3'b001), 32'h80000001, 32'hffffffff); // Shift by 31.
        run_transaction(enc_r(7'h00, 3'b101), 32'h80000001, 32'hffffffe0);
        run_transaction(enc_r(7'h00, 3'b101), 32'h80000001, 32'hffffffff);
        run_transaction(enc_r(7'h20, 3'b101), 32'h80000001, 32'hffffffe0);
        run_transaction(enc_r(7'h20, 3'b101), 32'h80000001, 32'hffffffff);

        // Register-immediate corners with negative immediates.
        run_transaction(enc_i(12'hfff, 3'b000), 32'h00000005, rand_word());
        run_transaction(enc_i(12'h800, 3'b000), 32'h00000000, rand_word());
        run_transaction(enc_i(12'hfff, 3'b010), 32'h00000000, rand_word());
        run_transaction(enc_i(12'hfff, 3'b011), 32'h00000005, rand_word());
        run_transaction(enc_i(12'hfff, 3'b100), 32'h12345678, rand_word());
        run_transaction(enc_i(12'h800, 3'b111), 32'hffffffff, rand_word());
        run_transaction(enc_i(12'hff0, 3'b110), 32'h00000000, rand_word());
        run_transaction(enc_i(12'h41f, 3'b101), 32'h80000000, rand_word()); // SRAI 31.
        run_transaction(enc_i(12'h404, 3'b101), 32'h80000000, rand_word());
        run_transaction(enc_i(12'h01f, 3'b101), 32'h80000000, rand_word());
        run_transaction(enc_i(12'h01f, 3'b001), 32'h00000001, rand_word());

        run_transaction(enc_u(20'hfffff), rand_word(), rand_word());
        run_transaction(enc_u(20'h00001), rand_word(), rand_word());

        // Illegal encodings.
        run_transaction(enc_opcode(7'h7f), rand_word(), rand_word());
        run_transaction(enc_opcode(7'b1100011), rand_word(), rand_word());
        run_transaction(enc_r(7'h20, 3'b100), rand_word(), rand_word());
        run_transaction(enc_r(7'h01, 3'b000), rand_word(), rand_word());
        run_transaction(enc_i(12'h020, 3'b001), rand_word(), rand_word());
        run_transaction(enc_i(12'h025, 3'b101), rand_word(), rand_word());
        run_transaction(enc_i(12'hc05, 3'b101), rand_word(), rand_word());

        // Random R-type where index 8 and 9 are SUB and SRA.
        for (op_idx = 0; op_idx < 10; op_idx++) begin
            f3 = (op_idx < 8) ? 3'(op_idx) : ((op_idx == 8) ? 3'b000 : 3'b101);
            f7 = (op_idx < 8) ? 7'h00 : 7'h20;
            for (n = 0; n < RAND_PER_OP; n++) begin
                run_transaction(enc_r(f7, f3), rand_word(), rand_word());
            end
        end

        // Random I-type where index 8 is SRAI.
        for (op_idx = 0; op_idx < 9; op_idx++) begin
            f3 = (op_idx < 8) ? 3'(op_idx) : 3'b101;
            for (n = 0; n < RAND_PER_OP; n++) begin
                w = rand_word();
                if (op_idx == 1 || op_idx == 5) begin
                    w[11:5] = 7'h00;
                end else if (op_idx == 8) begin
                    w[11:5] = 7'h20;
                end
                run_transaction(enc_i(w[11:0], f3), rand_word(), rand_word());
            end
        end

        for (n = 0; n < RAND_PER_OP; n++) begin
            w = rand_word();
            run_transaction(enc_u(w[19:0]), rand_word(), rand_word());
        end

        // Random words with mostly illegal funct fields.
        for (n = 0; n < NUM_RAND_WORDS; n++) begin
            w = rand_word();
            if (n % 4 == 0) begin
                w[6:0] = OPC_OP;
            end else if (n % 4 == 1) begin
                w[6:0] = OPC_OP_IMM;
            end else if (n % 4 == 2) begin
                w[6:0] = OPC_LUI;
            end
            run_transaction(w, rand_word(), rand_word());
        end

        $display("All tests passed");
        $finish;
    end

    initial begin : watchdog
        #(TIMEOUT);
        abort_run("watchdog timeout, a handshake did not complete in time");
    end

endmodule

`default_nettype wire

// ==== verilog.f ====
source/alu_pkg.sv
source/alu_if.sv
source/sklansky_adder.sv
source/alu.sv
source/alu_decoder.sv
source/exec_unit.sv
tests/exec_unit_tb.sv

// ==== Makefile ====
VERILATOR ?= verilator
FLAGS     ?= --assert --timing
TOP       ?= exec_unit_tb
RTL_TOP   ?= exec_unit
FILELIST  ?= verilog.f
OBJ_DIR   ?= obj_dir

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) --lint-only $(FLAGS) --top-module $(RTL_TOP) -f $(FILELIST)
	$(VERILATOR) --lint-only $(FLAGS) --top-module $(TOP) -f $(FILELIST)

sim:
	$(VERILATOR) --binary $(FLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)
	./$(OBJ_DIR)/V$(TOP)

clean:
	rm -rf $(OBJ_DIR)
